// ==== zap_decompile.f ====
hdl/zap_decompile_pkg.sv
hdl/zap_decompile_classify.sv
hdl/zap_decompile_mnemonic.sv
hdl/zap_decompile.sv
bench/zap_decompile_assertions.sv
bench/zap_decompile_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the decompiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
        -f zap_decompile.f --top-module zap_decompile_tb -o zap_decompile_sim \
        || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/zap_decompile_sim 2>&1)"
echo "$out"

echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1

// ==== bench/zap_decompile_tb.sv ====
// -----------------------------------------------
// Testbench for the ARM decompiler
// Table driven stimulus with random idle gaps
// -----------------------------------------------

`timescale 1ns/1ns

module zap_decompile_tb import zap_decompile_pkg::*; ();

localparam int MNEM_CHARS     = DEFAULT_MNEM_CHARS;
localparam int NUM_ENTRIES    = 22;
// Second half of the table goes in back to back
localparam int BURST_FROM     = NUM_ENTRIES / 2;
localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 4 + 20;
localparam int CLK_HALF       = 4;
localparam int DRIVE_DELAY    = 1;

typedef logic [8*MNEM_CHARS-1:0] text_t;

typedef struct packed
{
        instr_t      instr;
        insn_class_t cls;
        reg_num_t    rd;
        reg_num_t    rn;
        text_t       mnem;
} entry_t;

localparam text_t IGNORE_TEXT = "IGNORE  ";

logic                   i_clk;
logic                   i_arst_n;
instr_t                 i_instruction;
logic                   i_dav;
logic                   o_valid;
insn_class_t            o_class;
reg_num_t               o_rd;
reg_num_t               o_rn;
char_t [MNEM_CHARS-1:0] o_mnemonic;

entry_t      tbl [NUM_ENTRIES];
int          exp_idx_q [$];
int          exp_cycle_q [$];
int          cycle_cnt   = 0;
int          checked_cnt = 0;
logic [31:0] lfsr_state  = 32'hc22b;

zap_decompile #(
        .MNEM_CHARS (MNEM_CHARS)
) dut (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_instruction (i_instruction),
        .i_dav         (i_dav),
        .o_valid       (o_valid),
        .o_class       (o_class),
        .o_rd          (o_rd),
        .o_rn          (o_rn),
        .o_mnemonic    (o_mnemonic)
);

// -----------------------------------------------
// Stimulus table
// -----------------------------------------------
task automatic load_table();
        // Data processing immediate with MSR immediate as UNDEF
        tbl[0]  = '{32'hE2812003, CLASS_DP_IMM,  4'd2,  4'd1, "ADDAL   "};
        tbl[1]  = '{32'h02543010, CLASS_DP_IMM,  4'd3,  4'd4, "SUBEQ   "};
        tbl[2]  = '{32'h13A0500F, CLASS_DP_IMM,  4'd5,  4'd0, "MOVNE   "};
        tbl[3]  = '{32'hC3570001, CLASS_DP_IMM,  4'd0,  4'd7, "CMPGT   "};
        tbl[4]  = '{32'hE328F001, CLASS_UNKNOWN, 4'd0,  4'd0, "UNDEF   "};
        tbl[5]  = '{32'hB3C9A0FF, CLASS_DP_IMM,  4'd10, 4'd9, "BICLT   "};
        tbl[6]  = '{32'h43F0B000, CLASS_DP_IMM,  4'd11, 4'd0, "MVNMI   "};
        tbl[7]  = '{32'h6200C001, CLASS_DP_IMM,  4'd12, 4'd0, "ANDVS   "};
        // Branches
        tbl[8]  = '{32'hEA000010, CLASS_BRANCH,  4'd0,  4'd0, "BAL     "};
        tbl[9]  = '{32'h1B000020, CLASS_BRANCH,  4'd0,  4'd0, "BLNE    "};
        tbl[10] = '{32'h8BFFFFFE, CLASS_BRANCH,  4'd0,  4'd0, "BLHI    "};
        tbl[11] = '{32'hFA000000, CLASS_BRANCH,  4'd0,  4'd0, "BNV     "};
        // Load and store with all four load and byte pairs
        tbl[12] = '{32'hE5912004, CLASS_LS_IMM,  4'd2,  4'd1, "LDRAL   "};
        tbl[13] = '{32'h05834000, CLASS_LS_IMM,  4'd4,  4'd3, "STREQ   "};
        tbl[14] = '{32'h25D56001, CLASS_LS_IMM,  4'd6,  4'd5, "LDRCSB  "};
        tbl[15] = '{32'hD4C78000, CLASS_LS_IMM,  4'd8,  4'd7, "STRLEB  "};
        // SWI
        tbl[16] = '{32'hEF000011, CLASS_SWI,     4'd0,  4'd0, "SWIAL   "};
        tbl[17] = '{32'h3F123456, CLASS_SWI,     4'd0,  4'd0, "SWICC   "};
        // Multiply, coprocessor and register offset load are not decoded
        tbl[18] = '{32'hE0010392, CLASS_UNKNOWN, 4'd0,  4'd0, "UNDEF   "};
        tbl[19] = '{32'hEE000010, CLASS_UNKNOWN, 4'd0,  4'd0, "UNDEF   "};
        tbl[20] = '{32'hE7912003, CLASS_UNKNOWN, 4'd0,  4'd0, "UNDEF   "};
        tbl[21] = '{32'h5381D0F0, CLASS_DP_IMM,  4'd13, 4'd1, "ORRPL   "};
endtask

// -----------------------------------------------
// Helpers
// -----------------------------------------------

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

task automatic take_random_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
endtask

task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
endtask

task automatic check_value(input string name, input text_t got, input text_t exp);
        if (got !== exp)
        begin
                $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
                $display("TB FAILED");
                $fatal(1);
        end
endtask

// -----------------------------------------------
// Clock, cycle count and timeout
// -----------------------------------------------
initial
begin
        i_clk = 1'b0;
        forever #(CLK_HALF) i_clk = ~i_clk;
end

always @(posedge i_clk)
begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
                abort_run($sformatf("Timeout after %0d cycles, results still missing",
                                    cycle_cnt));
end

// -----------------------------------------------
// Stimulus
// -----------------------------------------------
initial
begin
        int   gap;
        logic b;

        i_arst_n      = 1'b0;
        i_instruction = '0;
        i_dav         = 1'b0;
        load_table();

        repeat (4) @(posedge i_clk);
        #(DRIVE_DELAY);
        i_arst_n = 1'b1;

        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
                @(posedge i_clk);
                #(DRIVE_DELAY);
                i_instruction = tbl[i].instr;
                i_dav         = 1'b1;
                // Result shows two edges later
                exp_idx_q.push_back(i);
                exp_cycle_q.push_back(cycle_cnt + 2);

                gap = 0;
                if (i < BURST_FROM)
                begin
                        take_random_bit(b);
                        gap[0] = b;
                        take_random_bit(b);
                        gap[1] = b;
                end
                if (gap != 0)
                begin
                        @(posedge i_clk);
                        #(DRIVE_DELAY);
                        i_dav         = 1'b0;
                        i_instruction = '0;
                        repeat (gap - 1) @(posedge i_clk);
                end
        end

        @(posedge i_clk);
        #(DRIVE_DELAY);
        i_dav         = 1'b0;
        i_instruction = '0;

        wait (checked_cnt == NUM_ENTRIES);
        // A few idle cycles to see IGNORE again
        repeat (4) @(posedge i_clk);

        if (dut.u_assertions.fail_cnt == 0)
        begin
                $display("TB PASSED");
                $finish;
        end
        else
        begin
                $display("TB FAILED");
                $fatal(1);
        end
end

// -----------------------------------------------
// Output checker on the falling edge
// -----------------------------------------------
always @(negedge i_clk)
begin
        int idx;

        if (i_arst_n)
        begin
                if (o_valid)
                begin
                        if (exp_idx_q.size() == 0)
                        begin
                                abort_run("o_valid went high with no instruction in flight");
                        end
                        else
                        begin
                                idx = exp_idx_q.pop_front();
                                check_value("cycle", text_t'(cycle_cnt),
                                            text_t'(exp_cycle_q.pop_front()));
                                check_value("o_class", text_t'(o_class), text_t'(tbl[idx].cls));
                                check_value("o_rd", text_t'(o_rd), text_t'(tbl[idx].rd));
                                check_value("o_rn", text_t'(o_rn), text_t'(tbl[idx].rn));
                                check_value("o_mnemonic", text_t'(o_mnemonic), tbl[idx].mnem);
                                checked_cnt = checked_cnt + 1;
                        end
                end
                else
                begin
                        check_value("o_mnemonic", text_t'(o_mnemonic), IGNORE_TEXT);
                        check_value("o_class", text_t'(o_class), text_t'(CLASS_UNKNOWN));
                end
        end
end

// Assertion failure monitor
always @(negedge i_clk)
begin
        if (dut.u_assertions.fail_cnt != 0)
                abort_run("A bound assertion on the DUT failed");
end

endmodule

// ==== bench/zap_decompile_assertions.sv ====
// -----------------------------------------------
// Protocol assertions for the ARM decompiler
// -----------------------------------------------

`timescale 1ns/1ns

module zap_decompile_assertions import zap_decompile_pkg::*; #(
        parameter int MNEM_CHARS = DEFAULT_MNEM_CHARS
) (
        input logic                   i_clk,
        input logic                   i_arst_n,
        input logic                   i_dav,
        input logic                   o_valid,
        input char_t [MNEM_CHARS-1:0] o_mnemonic
);

int unsigned fail_cnt = 0;

// Reset holds the output strobe low
valid_low_in_reset: assert property (@(posedge i_clk) !i_arst_n |=> !o_valid)
else
begin
        $error("o_valid high while in reset");
        fail_cnt++;
end

// Fixed two cycle latency, one result per strobe
valid_follows_dav: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid == $past(i_dav, 2))
else
begin
        $error("o_valid does not follow i_dav two cycles later");
        fail_cnt++;
end

mnemonic_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid |-> !$isunknown(o_mnemonic))
else
begin
        $error("o_mnemonic has unknown bits while o_valid is high");
        fail_cnt++;
end

endmodule

bind zap_decompile zap_decompile_assertions #(
        .MNEM_CHARS (MNEM_CHARS)
) u_assertions (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_dav      (i_dav),
        .o_valid    (o_valid),
        .o_mnemonic (o_mnemonic)
);

// ==== hdl/zap_decompile.sv ====
// -----------------------------------------------
// ARM instruction decompiler for debug
// Two stage classify and mnemonic pipeline
// -----------------------------------------------

`timescale 1ns/1ns

module zap_decompile import zap_decompile_pkg::*; #(
        parameter int MNEM_CHARS = DEFAULT_MNEM_CHARS
) (
        input  logic                   i_clk,
        input  logic                   i_arst_n,
        input  instr_t                 i_instruction,
        input  logic                   i_dav,
        output logic                   o_valid,
        output insn_class_t            o_class,
        output reg_num_t               o_rd,
        output reg_num_t               o_rn,
        output char_t [MNEM_CHARS-1:0] o_mnemonic
);

// Stage 1 to stage 2
logic        s1_valid;
insn_class_t s1_class;
cond_t       s1_cond;
alu_op_t     s1_op;
logic        s1_link;
logic        s1_load;
logic        s1_byte;
reg_num_t    s1_rd;
reg_num_t    s1_rn;

zap_decompile_classify u_classify (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_instruction (i_instruction),
        .i_dav         (i_dav),
        .o_valid       (s1_valid),
        .o_class       (s1_class),
        .o_cond        (s1_cond),
        .o_op          (s1_op),
        .o_link        (s1_link),
        .o_load        (s1_load),
        .o_byte        (s1_byte),
        .o_rd          (s1_rd),
        .o_rn          (s1_rn)
);

zap_decompile_mnemonic #(
        .MNEM_CHARS (MNEM_CHARS)
) u_mnemonic (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (s1_valid),
        .i_class    (s1_class),
        .i_cond     (s1_cond),
        .i_op       (s1_op),
        .i_link     (s1_link),
        .i_load     (s1_load),
        .i_byte     (s1_byte),
        .i_rd       (s1_rd),
        .i_rn       (s1_rn),
        .o_valid    (o_valid),
        .o_class    (o_class),
        .o_rd       (o_rd),
        .o_rn       (o_rn),
        .o_mnemonic (o_mnemonic)
);

endmodule

// ==== hdl/zap_decompile_mnemonic.sv ====
// -----------------------------------------------
// ARM decompiler, second pipeline stage
// Builds the space padded ASCII mnemonic
// -----------------------------------------------

`timescale 1ns/1ns

module zap_decompile_mnemonic import zap_decompile_pkg::*; #(
        parameter int MNEM_CHARS = DEFAULT_MNEM_CHARS
) (
        input  logic                   i_clk,
        input  logic                   i_arst_n,
        input  logic                   i_valid,
        input  insn_class_t            i_class,
        input  cond_t                  i_cond,
        input  alu_op_t                i_op,
        input  logic                   i_link,
        input  logic                   i_load,
        input  logic                   i_byte,
        input  reg_num_t               i_rd,
        input  reg_num_t               i_rn,
        output logic                   o_valid,
        output insn_class_t            o_class,
        output reg_num_t               o_rd,
        output reg_num_t               o_rn,
        output char_t [MNEM_CHARS-1:0] o_mnemonic
);

typedef char_t [MNEM_CHARS-1:0] mnem_t;
typedef char_t [WORD_CHARS-1:0] word_t;

// -----------------------------------------------
// Text helpers
// -----------------------------------------------

// Position 0 is the leftmost character, held in the top byte
function automatic mnem_t put_char(input mnem_t text, input int pos, input char_t ch);
        mnem_t res;

        res = text;
        if (pos < MNEM_CHARS)
                res[MNEM_CHARS-1-pos] = ch;
        return res;
endfunction

// Word is right aligned, so its first char sits at index len-1
function automatic mnem_t put_word(input mnem_t text, input int pos, input word_t word,
                                   input int len);
        mnem_t res;

        res = text;
        for (int k = 0; k < WORD_CHARS; k++)
        begin
                if (k < len)
                        res = put_char(res, pos + k, word[len-1-k]);
        end
        return res;
endfunction

function automatic char_t [1:0] cond_text(input cond_t cond);
        case (cond)
        4'd0:    return "EQ";
        4'd1:    return "NE";
        4'd2:    return "CS";
        4'd3:    return "CC";
        4'd4:    return "MI";
        4'd5:    return "PL";
        4'd6:    return "VS";
        4'd7:    return "VC";
        4'd8:    return "HI";
        4'd9:    return "LS";
        4'd10:   return "GE";
        4'd11:   return "LT";
        4'd12:   return "GT";
        4'd13:   return "LE";
        4'd14:   return "AL";
        default: return "NV";
        endcase
endfunction

function automatic char_t [2:0] op_name(input alu_op_t op);
        case (op)
        4'd0:    return "AND";
        4'd1:    return "EOR";
        4'd2:    return "SUB";
        4'd3:    return "RSB";
        4'd4:    return "ADD";
        4'd5:    return "ADC";
        4'd6:    return "SBC";
        4'd7:    return "RSC";
        4'd8:    return "TST";
        4'd9:    return "TEQ";
        4'd10:   return "CMP";
        4'd11:   return "CMN";
        4'd12:   return "ORR";
        4'd13:   return "MOV";
        4'd14:   return "BIC";
        default: return "MVN";
        endcase
endfunction

localparam char_t SPACE       = " ";
localparam mnem_t BLANK_TEXT  = {MNEM_CHARS{SPACE}};
localparam mnem_t IGNORE_TEXT = put_word(BLANK_TEXT, 0, word_t'("IGNORE"), 6);

mnem_t mnem_d;

// -----------------------------------------------
// Mnemonic assembly
// -----------------------------------------------
always_comb
begin
        mnem_d = BLANK_TEXT;

        if (!i_valid)
        begin
                mnem_d = IGNORE_TEXT;
        end
        else
        begin
                case (i_class)
                CLASS_DP_IMM:
                begin
                        mnem_d = put_word(mnem_d, 0, word_t'(op_name(i_op)), 3);
                        mnem_d = put_word(mnem_d, 3, word_t'(cond_text(i_cond)), 2);
                end
                CLASS_BRANCH:
                begin
                        mnem_d = put_char(mnem_d, 0, "B");
                        if (i_link)
                                mnem_d = put_char(mnem_d, 1, "L");
                        mnem_d = put_word(mnem_d, i_link ? 2 : 1,
                                          word_t'(cond_text(i_cond)), 2);
                end
                CLASS_LS_IMM:
                begin
                        mnem_d = put_word(mnem_d, 0, word_t'(i_load ? "LDR" : "STR"), 3);
                        mnem_d = put_word(mnem_d, 3, word_t'(cond_text(i_cond)), 2);
                        // Byte suffix follows the condition, old ARM syntax
                        if (i_byte)
                                mnem_d = put_char(mnem_d, 5, "B");
                end
                CLASS_SWI:
                begin
                        mnem_d = put_word(mnem_d, 0, word_t'("SWI"), 3);
                        mnem_d = put_word(mnem_d, 3, word_t'(cond_text(i_cond)), 2);
                end
                default:
                begin
                        mnem_d = put_word(mnem_d, 0, word_t'("UNDEF"), 5);
                end
                endcase
        end
end

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                o_valid    <= 1'b0;
                o_class    <= CLASS_UNKNOWN;
                o_mnemonic <= IGNORE_TEXT;
        end
        else
        begin
                o_valid    <= i_valid;
                o_class    <= i_class;
                o_mnemonic <= mnem_d;
        end
end

always_ff @(posedge i_clk)
begin
        o_rd <= i_rd;
        o_rn <= i_rn;
end

endmodule

// ==== hdl/zap_decompile_classify.sv ====
// -----------------------------------------------
// First pipeline stage of the ARM decompiler
// Classifies the instruction and extracts fields
// -----------------------------------------------

`timescale 1ns/1ns

module zap_decompile_classify import zap_decompile_pkg::*; (
        input  logic        i_clk,
        input  logic        i_arst_n,
        input  instr_t      i_instruction,
        input  logic        i_dav,
        output logic        o_valid,
        output insn_class_t o_class,
        output cond_t       o_cond,
        output alu_op_t     o_op,
        output logic        o_link,
        output logic        o_load,
        output logic        o_byte,
        output reg_num_t    o_rd,
        output reg_num_t    o_rn
);

insn_class_t cls_d;
cond_t       cond_d;
alu_op_t     op_d;
logic        link_d;
logic        load_d;
logic        byte_d;
reg_num_t    rd_d;
reg_num_t    rn_d;
logic        is_msr_imm;

// MSR immediate sits in the TST..CMN slots with S clear
assign is_msr_imm = (i_instruction[MSR_HI:MSR_LO] == MSR_PATTERN) && !i_instruction[S_BIT];

always_comb
begin
        cls_d  = CLASS_UNKNOWN;
        cond_d = '0;
        op_d   = '0;
        link_d = 1'b0;
        load_d = 1'b0;
        byte_d = 1'b0;
        rd_d   = '0;
        rn_d   = '0;

        // SWI first, then the type field in priority order
        if (i_dav)
        begin
                if (i_instruction[SWI_HI:SWI_LO] == SWI_PATTERN)
                        cls_d = CLASS_SWI;
                else if (i_instruction[TYPE_HI:TYPE_LO] == TYPE_BRANCH)
                        cls_d = CLASS_BRANCH;
                else if (i_instruction[TYPE_HI:TYPE_LO] == TYPE_DP_IMM && !is_msr_imm)
                        cls_d = CLASS_DP_IMM;
                else if (i_instruction[TYPE_HI:TYPE_LO] == TYPE_LS_IMM)
                        cls_d = CLASS_LS_IMM;
        end

        // Only fields of the chosen class survive
        case (cls_d)
        CLASS_DP_IMM:
        begin
                cond_d = i_instruction[COND_HI:COND_LO];
                op_d   = i_instruction[OP_HI:OP_LO];
                rd_d   = i_instruction[RD_HI:RD_LO];
                rn_d   = i_instruction[RN_HI:RN_LO];
        end
        CLASS_BRANCH:
        begin
                cond_d = i_instruction[COND_HI:COND_LO];
                link_d = i_instruction[LINK_BIT];
        end
        CLASS_LS_IMM:
        begin
                cond_d = i_instruction[COND_HI:COND_LO];
                load_d = i_instruction[LOAD_BIT];
                byte_d = i_instruction[BYTE_BIT];
                rd_d   = i_instruction[RD_HI:RD_LO];
                rn_d   = i_instruction[RN_HI:RN_LO];
        end
        CLASS_SWI:
        begin
                cond_d = i_instruction[COND_HI:COND_LO];
        end
        default:
        begin
                cond_d = '0;
        end
        endcase
end

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                o_valid <= 1'b0;
                o_class <= CLASS_UNKNOWN;
                o_cond  <= '0;
                o_op    <= '0;
                o_link  <= 1'b0;
                o_load  <= 1'b0;
                o_byte  <= 1'b0;
        end
        else
        begin
                o_valid <= i_dav;
                o_class <= cls_d;
                o_cond  <= cond_d;
                o_op    <= op_d;
                o_link  <= link_d;
                o_load  <= load_d;
                o_byte  <= byte_d;
        end
end

// Register numbers for the mnemonic stage
always_ff @(posedge i_clk)
begin
        o_rd <= rd_d;
        o_rn <= rn_d;
end

endmodule

// ==== hdl/zap_decompile_pkg.sv ====
// -----------------------------------------------
// ARM decompiler shared definitions
// Widths, instruction class and field positions
// -----------------------------------------------

package zap_decompile_pkg;

        // -----------------------------------------------
        // Widths
        // -----------------------------------------------
        localparam int INSTR_W            = 32;
        localparam int REG_W              = 4;
        localparam int COND_W             = 4;
        localparam int OP_W               = 4;
        localparam int CHAR_W             = 8;
        localparam int CLASS_W            = 3;

        // Longest single word placed into the mnemonic
        localparam int WORD_CHARS         = 6;
        localparam int DEFAULT_MNEM_CHARS = 8;

        typedef logic [INSTR_W-1:0] instr_t;
        typedef logic [REG_W-1:0]   reg_num_t;
        typedef logic [COND_W-1:0]  cond_t;
        typedef logic [OP_W-1:0]    alu_op_t;
        typedef logic [CHAR_W-1:0]  char_t;

        typedef enum logic [CLASS_W-1:0]
        {
                CLASS_DP_IMM,
                CLASS_BRANCH,
                CLASS_LS_IMM,
                CLASS_SWI,
                CLASS_UNKNOWN
        } insn_class_t;

        // -----------------------------------------------
        // Field positions
        // -----------------------------------------------
        localparam int COND_HI  = 31;
        localparam int COND_LO  = 28;
        localparam int SWI_HI   = 27;
        localparam int SWI_LO   = 24;
        localparam int TYPE_HI  = 27;
        localparam int TYPE_LO  = 25;
        localparam int OP_HI    = 24;
        localparam int OP_LO    = 21;
        localparam int MSR_HI   = 24;
        localparam int MSR_LO   = 23;
        localparam int RN_HI    = 19;
        localparam int RN_LO    = 16;
        localparam int RD_HI    = 15;
        localparam int RD_LO    = 12;
        localparam int LINK_BIT = 24;
        localparam int BYTE_BIT = 22;
        localparam int LOAD_BIT = 20;
        localparam int S_BIT    = 20;

        // Encoding patterns for the fields above
        localparam logic [3:0] SWI_PATTERN = 4'b1111;
        localparam logic [2:0] TYPE_BRANCH = 3'b101;
        localparam logic [2:0] TYPE_DP_IMM = 3'b001;
        localparam logic [2:0] TYPE_LS_IMM = 3'b010;
        localparam logic [1:0] MSR_PATTERN = 2'b10;

endpackage
